// ==== Bender.yml ====
package:
  name: p4_egress

sources:
  - design/egress_pkg.sv
  - design/egress_demux.sv
  - design/egress_port_buffer.sv
  - design/egress_port_serializer.sv
  - design/p4_egress.sv
  - target: simulation
    files:
      - sim/tb_p4_egress.sv

// ==== design/egress_demux.sv ====
////////////////////////////////////////
// Input has no back-pressure, a beat is always taken
// Port numbers of NUM_PORTS or more are discarded
////////////////////////////////////////

module egress_demux
    import egress_pkg::*;
#(
    parameter int NUM_PORTS = 4
)(
    input  logic                 egr_bus,
    input  logic                 rst_n,
    input  egr_beat_t            egr_in,
    output egr_word_t            wr_word,
    output logic [NUM_PORTS-1:0] wr_en
);

    ////////////////////////////////////////
    // Shared word register

    // One copy of the payload feeds every port buffer
    always_ff @(posedge egr_bus) begin
        wr_word <= egr_in.word;
    end

    ////////////////////////////////////////
    // Port strobe decode

    always_ff @(posedge egr_bus) begin
        if (!rst_n) begin
            wr_en <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                wr_en[p] <= egr_in.valid && (egr_in.port == port_id_t'(p));
            end
        end
    end

    ////////////////////////////////////////
    // Checks

    // At most one port is written per cycle
    assert property (@(posedge egr_bus) disable iff (!rst_n)
        $onehot0(wr_en))
    else $error("egress_demux: wr_en not one-hot");

endmodule

// ==== design/egress_pkg.sv ====
////////////////////////////////////////
// Widths are fixed at 8-byte bus words and 2-byte port beats
// Keep bits are contiguous from byte 0 and only a last beat may be partial
////////////////////////////////////////

package egress_pkg;

    ////////////////////////////////////////
    // Sizes

    localparam int BUS_BYTES      = 8;
    localparam int PORT_BYTES     = 2;
    localparam int BEATS_PER_WORD = BUS_BYTES / PORT_BYTES;
    localparam int PORT_ID_BITS   = 4;

    ////////////////////////////////////////
    // Plain vector types

    typedef logic [BUS_BYTES*8-1:0]  bus_data_t;
    typedef logic [BUS_BYTES-1:0]    bus_keep_t;
    typedef logic [PORT_BYTES*8-1:0] port_data_t;
    typedef logic [PORT_BYTES-1:0]   port_keep_t;
    typedef logic [PORT_ID_BITS-1:0] port_id_t;
    // Wraps silently
    typedef logic [31:0]             cnt_t;

    ////////////////////////////////////////
    // Beat structs

    typedef struct packed {
        bus_data_t data;
        bus_keep_t keep;
        logic      last;
    } egr_word_t;

    typedef struct packed {
        logic      valid;
        port_id_t  port;
        egr_word_t word;
    } egr_beat_t;

    typedef struct packed {
        port_data_t data;
        port_keep_t keep;
        logic       last;
    } port_beat_t;

    typedef struct packed {
        cnt_t tx_pkts;
        cnt_t tx_bytes;
        cnt_t drop_pkts;
    } port_cnts_t;

endpackage

// ==== design/egress_port_buffer.sv ====
////////////////////////////////////////
// BUF_WORDS must be a power of two and hold at least one MTU packet
// Admission is decided at the first beat, a dropped packet is discarded whole
////////////////////////////////////////

module egress_port_buffer
    import egress_pkg::*;
#(
    parameter int BUF_WORDS = 64,
    parameter int MTU_BYTES = 128
)(
    input  logic      egr_bus,
    input  logic      rst_n,
    input  egr_word_t wr_word,
    input  logic      wr_en,
    input  logic      port_enable,
    output egr_word_t rd_word,
    output logic      rd_valid,
    input  logic      rd_pop,
    output logic      drop
);

    localparam int MAX_PKT_WORDS = (MTU_BYTES + BUS_BYTES - 1) / BUS_BYTES;
    localparam int ADDR_BITS     = $clog2(BUF_WORDS);

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [ADDR_BITS:0]   fill_t;
    typedef enum logic [1:0] {
        PKT_IDLE,
        PKT_ACCEPT,
        PKT_DISCARD
    } pkt_state_t;

    egr_word_t  mem [BUF_WORDS];
    addr_t      wr_ptr;
    addr_t      rd_ptr;
    fill_t      fill;
    pkt_state_t state;
    logic       admit;
    logic       do_write;

    // Room for a worst-case packet must exist at the first beat
    assign admit    = port_enable && ((BUF_WORDS - int'(fill)) >= MAX_PKT_WORDS);
    assign do_write = wr_en && ((state == PKT_ACCEPT) || (state == PKT_IDLE && admit));

    ////////////////////////////////////////
    // Word store

    always_ff @(posedge egr_bus) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge egr_bus) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill <= fill + fill_t'(do_write) - fill_t'(rd_pop);
        end
    end

    // Head word falls through
    assign rd_word  = mem[rd_ptr];
    assign rd_valid = (fill != '0);

    ////////////////////////////////////////
    // Packet admission FSM

    always_ff @(posedge egr_bus) begin
        if (!rst_n) begin
            state <= PKT_IDLE;
            drop  <= 1'b0;
        end else begin
            drop <= wr_en && (state == PKT_IDLE) && !admit;
            if (wr_en) begin
                case (state)
                    PKT_IDLE: begin
                        if (!wr_word.last) begin
                            state <= admit ? PKT_ACCEPT : PKT_DISCARD;
                        end
                    end
                    default: begin
                        if (wr_word.last) begin
                            state <= PKT_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // Checks

    assert property (@(posedge egr_bus) disable iff (!rst_n)
        do_write |-> (int'(fill) < BUF_WORDS))
    else $error("egress_port_buffer: write while full");

    // Serializer only pops a present head
    assert property (@(posedge egr_bus) disable iff (!rst_n)
        rd_pop |-> rd_valid)
    else $error("egress_port_buffer: pop while empty");

endmodule

// ==== design/egress_port_serializer.sv ====
////////////////////////////////////////
// Slices each word into 2-byte beats, lowest bytes first
// Counters wrap and cnts_clear wins over a same-cycle increment
////////////////////////////////////////

module egress_port_serializer
    import egress_pkg::*;
(
    input  logic       egr_bus,
    input  logic       rst_n,
    input  egr_word_t  rd_word,
    input  logic       rd_valid,
    output logic       rd_pop,
    input  logic       drop,
    input  logic       cnts_clear,
    output port_beat_t port_out,
    output logic       port_valid,
    input  logic       port_ready,
    output port_cnts_t cnts
);

    localparam int IDX_BITS = (BEATS_PER_WORD > 1) ? $clog2(BEATS_PER_WORD) : 1;

    logic [IDX_BITS-1:0] beat_idx;
    bus_keep_t           rem_keep;
    port_beat_t          next_beat;
    logic                slice_final;
    logic                load;
    logic                xfer;
    cnt_t                beat_bytes;

    ////////////////////////////////////////
    // Slice select

    // Nothing left above this slice means it is the word's final one
    assign rem_keep    = bus_keep_t'(rd_word.keep >> ((beat_idx + 1) * PORT_BYTES));
    assign slice_final = (rem_keep == '0);

    assign next_beat.data = rd_word.data[beat_idx*PORT_BYTES*8 +: PORT_BYTES*8];
    assign next_beat.keep = rd_word.keep[beat_idx*PORT_BYTES +: PORT_BYTES];
    assign next_beat.last = rd_word.last && slice_final;

    // Beat register empty or draining this cycle
    assign load   = rd_valid && (!port_valid || port_ready);
    assign rd_pop = load && slice_final;
    assign xfer   = port_valid && port_ready;

    always_ff @(posedge egr_bus) begin
        if (load) begin
            port_out <= next_beat;
        end
    end

    always_ff @(posedge egr_bus) begin
        if (!rst_n) begin
            port_valid <= 1'b0;
            beat_idx   <= '0;
        end else begin
            if (load) begin
                port_valid <= 1'b1;
                beat_idx   <= slice_final ? '0 : beat_idx + 1'b1;
            end else if (port_ready) begin
                port_valid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Port counters

    always_comb begin
        beat_bytes = '0;
        for (int b = 0; b < PORT_BYTES; b++) begin
            beat_bytes = beat_bytes + cnt_t'(port_out.keep[b]);
        end
    end

    always_ff @(posedge egr_bus) begin
        if (!rst_n) begin
            cnts <= '0;
        end else if (cnts_clear) begin
            cnts <= '0;
        end else begin
            if (xfer) begin
                cnts.tx_bytes <= cnts.tx_bytes + beat_bytes;
                if (port_out.last) begin
                    cnts.tx_pkts <= cnts.tx_pkts + 1'b1;
                end
            end
            if (drop) begin
                cnts.drop_pkts <= cnts.drop_pkts + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Checks

    // A stalled beat is held until the port takes it
    assert property (@(posedge egr_bus) disable iff (!rst_n)
        (port_valid && !port_ready) |=> (port_valid && $stable(port_out)))
    else $error("egress_port_serializer: beat changed under stall");

endmodule

// ==== design/p4_egress.sv ====
////////////////////////////////////////
// Single clock egress stage, NUM_PORTS from 1 to 16
// Input is never stalled, full or disabled ports drop whole packets
////////////////////////////////////////

module p4_egress
    import egress_pkg::*;
#(
    parameter int NUM_PORTS = 4,
    parameter int BUF_WORDS = 64,
    parameter int MTU_BYTES = 128
)(
    input  logic                 egr_bus,
    input  logic                 rst_n,
    input  egr_beat_t            egr_in,
    input  logic [NUM_PORTS-1:0] port_ready,
    input  logic [NUM_PORTS-1:0] port_enable,
    input  logic [NUM_PORTS-1:0] cnts_clear,
    output port_beat_t           port_out [NUM_PORTS-1:0],
    output logic [NUM_PORTS-1:0] port_valid,
    output port_cnts_t           port_cnts [NUM_PORTS-1:0],
    output logic [NUM_PORTS-1:0] buf_full_drop
);

    egr_word_t            wr_word;
    logic [NUM_PORTS-1:0] wr_en;
    egr_word_t            rd_word [NUM_PORTS-1:0];
    logic [NUM_PORTS-1:0] rd_valid;
    logic [NUM_PORTS-1:0] rd_pop;

    egress_demux #(
        .NUM_PORTS ( NUM_PORTS )
    ) demux0 (
        .egr_bus ( egr_bus ),
        .rst_n   ( rst_n   ),
        .egr_in  ( egr_in  ),
        .wr_word ( wr_word ),
        .wr_en   ( wr_en   )
    );

    ////////////////////////////////////////
    // Per-port buffer and serializer

    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
        egress_port_buffer #(
            .BUF_WORDS ( BUF_WORDS ),
            .MTU_BYTES ( MTU_BYTES )
        ) buf0 (
            .egr_bus     ( egr_bus          ),
            .rst_n       ( rst_n            ),
            .wr_word     ( wr_word          ),
            .wr_en       ( wr_en[p]         ),
            .port_enable ( port_enable[p]   ),
            .rd_word     ( rd_word[p]       ),
            .rd_valid    ( rd_valid[p]      ),
            .rd_pop      ( rd_pop[p]        ),
            .drop        ( buf_full_drop[p] )
        );

        egress_port_serializer ser0 (
            .egr_bus    ( egr_bus          ),
            .rst_n      ( rst_n            ),
            .rd_word    ( rd_word[p]       ),
            .rd_valid   ( rd_valid[p]      ),
            .rd_pop     ( rd_pop[p]        ),
            .drop       ( buf_full_drop[p] ),
            .cnts_clear ( cnts_clear[p]    ),
            .port_out   ( port_out[p]      ),
            .port_valid ( port_valid[p]    ),
            .port_ready ( port_ready[p]    ),
            .cnts       ( port_cnts[p]     )
        );
    end

endmodule

// ==== p4_egress.f ====
design/egress_pkg.sv
design/egress_demux.sv
design/egress_port_buffer.sv
design/egress_port_serializer.sv
design/p4_egress.sv
sim/tb_p4_egress.sv

// ==== sim/tb_p4_egress.sv ====
////////////////////////////////////////
// Random packets checked against a per-port expected-beat model
// The stall case relies on no pops from a port whose ready is held low
////////////////////////////////////////

module tb_p4_egress
    import egress_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PORTS = 4;
    localparam int BUF_WORDS = 64;
    localparam int MTU_BYTES = 128;
    localparam int MAX_WORDS = MTU_BYTES / BUS_BYTES;
    localparam int PERIOD    = 100;
    localparam int SEED      = 32'h59172f69;
    localparam int N_RAND    = 60;
    localparam int N_STALL   = 8;
    localparam int N_OFF     = 4;
    localparam int NUM_PKTS  = N_RAND + 2 * N_STALL + N_OFF + 2;

    logic                 egr_bus;
    logic                 rst_n;
    egr_beat_t            egr_in;
    logic [NUM_PORTS-1:0] port_ready;
    logic [NUM_PORTS-1:0] port_enable;
    logic [NUM_PORTS-1:0] cnts_clear;
    port_beat_t           port_out [NUM_PORTS-1:0];
    logic [NUM_PORTS-1:0] port_valid;
    port_cnts_t           port_cnts [NUM_PORTS-1:0];
    logic [NUM_PORTS-1:0] buf_full_drop;

    // Expected beats, bit 19 marks the final slice of a word
    logic [19:0]          exp_q [NUM_PORTS][$];
    int                   out_words [NUM_PORTS];
    cnt_t                 exp_pkts [NUM_PORTS];
    cnt_t                 exp_bytes [NUM_PORTS];
    cnt_t                 exp_drops [NUM_PORTS];
    int                   total_drops [NUM_PORTS];
    int                   seen_drops [NUM_PORTS];
    logic [NUM_PORTS-1:0] stall;
    int                   phase;
    int                   beat_errs;
    int                   cnt_errs;
    int                   other_errs;
    integer               pkt_seed;
    integer               rdy_seed;

    p4_egress #(
        .NUM_PORTS ( NUM_PORTS ),
        .BUF_WORDS ( BUF_WORDS ),
        .MTU_BYTES ( MTU_BYTES )
    ) dut0 (.*);

    initial begin
        egr_bus = 1'b0;
        forever #(PERIOD / 2) egr_bus = ~egr_bus;
    end

    initial begin
        rdy_seed   = SEED;
        port_ready = '0;
        forever begin
            @(negedge egr_bus);
            for (int p = 0; p < NUM_PORTS; p++) begin
                port_ready[p] = !stall[p] && ($random(rdy_seed) & 1);
            end
        end
    end

    initial begin
        #(NUM_PKTS * 128 * PERIOD + 1000 * PERIOD);
        $display("Timeout: the ports did not drain within the time limit");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Checks

    assert property (@(posedge egr_bus) !rst_n |=> (port_valid == '0) && (buf_full_drop == '0))
    else begin
        $display("** Error @ %0t: port_valid or buf_full_drop set after reset", $time);
        other_errs++;
    end

    // Spaced traffic to enabled ports never overflows
    assert property (@(posedge egr_bus) disable iff (!rst_n)
        (phase == 1) |-> (buf_full_drop == '0))
    else begin
        $display("** Error @ %0t: drop pulse %b during spaced traffic", $time, buf_full_drop);
        other_errs++;
    end

    always @(posedge egr_bus) begin : port_check
        logic [19:0] want;
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (buf_full_drop[p]) begin
                    seen_drops[p]++;
                end
                if (port_valid[p] && port_ready[p]) begin
                    assert (exp_q[p].size() != 0) else begin
                        $display("** Error @ %0t: port %0d sent an unexpected beat", $time, p);
                        beat_errs++;
                    end
                    if (exp_q[p].size() != 0) begin
                        want = exp_q[p].pop_front();
                        assert (port_out[p] == port_beat_t'(want[18:0])) else begin
                            $display("** Error @ %0t: port %0d beat %h, expected %h",
                                     $time, p, port_out[p], want[18:0]);
                            beat_errs++;
                        end
                        if (want[19]) begin
                            out_words[p]--;
                        end
                        exp_bytes[p] += cnt_t'(want[2]) + cnt_t'(want[1]);
                        exp_pkts[p]  += cnt_t'(want[0]);
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // Model and stimulus

    function automatic void push_word(input int p, input egr_word_t w, input int nb);
        port_beat_t pb;
        int         ns;
        ns = (nb + PORT_BYTES - 1) / PORT_BYTES;
        for (int s = 0; s < ns; s++) begin
            pb.data = w.data[s*16 +: 16];
            pb.keep = (nb - 2 * s >= 2) ? 2'b11 : 2'b01;
            pb.last = w.last && (s == ns - 1);
            exp_q[p].push_back({s == ns - 1, pb});
        end
    endfunction

    task automatic send_pkt(input int p, input int len);
        egr_beat_t beat;
        int        nwords;
        int        nb;
        logic      admit;
        nwords = (len + BUS_BYTES - 1) / BUS_BYTES;
        admit  = 1'b0;
        if (p < NUM_PORTS) begin
            // Model fill never undercounts the buffer
            admit = port_enable[p] && (BUF_WORDS - out_words[p] >= MAX_WORDS);
            if (admit) begin
                out_words[p] += nwords;
            end else begin
                exp_drops[p]++;
                total_drops[p]++;
            end
        end
        for (int w = 0; w < nwords; w++) begin
            nb = (len - w * BUS_BYTES > BUS_BYTES) ? BUS_BYTES : len - w * BUS_BYTES;
            beat           = '0;
            beat.valid     = 1'b1;
            beat.port      = port_id_t'(p);
            beat.word.last = (w == nwords - 1);
            for (int b = 0; b < nb; b++) begin
                beat.word.data[b*8 +: 8] = 8'($random(pkt_seed));
                beat.word.keep[b]        = 1'b1;
            end
            if (admit) begin
                push_word(p, beat.word, nb);
            end
            egr_in = beat;
            @(negedge egr_bus);
        end
        egr_in = '0;
    endtask

    function automatic int pending(input int skip);
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (p != skip) begin
                n += exp_q[p].size();
            end
        end
        return n;
    endfunction

    task automatic drain(input int skip);
        while (pending(skip) != 0) begin
            @(negedge egr_bus);
        end
        repeat (4) @(negedge egr_bus);
    endtask

    task automatic check_cnts(input int p);
        assert ((port_cnts[p].tx_pkts == exp_pkts[p]) && (port_cnts[p].tx_bytes == exp_bytes[p])
                && (port_cnts[p].drop_pkts == exp_drops[p])) else begin
            $display("** Error @ %0t: port %0d counters %0d/%0d/%0d, expected %0d/%0d/%0d",
                     $time, p, port_cnts[p].tx_pkts, port_cnts[p].tx_bytes,
                     port_cnts[p].drop_pkts, exp_pkts[p], exp_bytes[p], exp_drops[p]);
            cnt_errs++;
        end
    endtask

    initial begin : main
        int p;
        pkt_seed    = SEED;
        rst_n       = 1'b0;
        egr_in      = '0;
        port_enable = '1;
        cnts_clear  = '0;
        stall       = '0;
        phase       = 0;
        beat_errs   = 0;
        cnt_errs    = 0;
        other_errs  = 0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            out_words[i]   = 0;
            exp_pkts[i]    = '0;
            exp_bytes[i]   = '0;
            exp_drops[i]   = '0;
            total_drops[i] = 0;
            seen_drops[i]  = 0;
        end
        repeat (3) @(negedge egr_bus);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_PORTS; i++) begin
            check_cnts(i);
        end

        // Spaced traffic, some of it to ports that do not exist
        phase = 1;
        for (int i = 0; i < N_RAND; i++) begin
            p = $unsigned($random(pkt_seed)) % (NUM_PORTS + 2);
            while (p < NUM_PORTS && exp_q[p].size() > BUF_WORDS - MAX_WORDS) begin
                @(negedge egr_bus);
            end
            send_pkt(p, 1 + $unsigned($random(pkt_seed)) % MTU_BYTES);
        end
        drain(-1);
        phase = 0;

        // Port 1 stalled past its capacity while ports 0 and 3 flow
        stall[1] = 1'b1;
        repeat (2) @(negedge egr_bus);
        for (int i = 0; i < N_STALL; i++) begin
            send_pkt(1, MTU_BYTES);
            send_pkt((i % 2) ? 3 : 0, 1 + $unsigned($random(pkt_seed)) % MTU_BYTES);
        end
        drain(1);
        stall[1] = 1'b0;
        drain(-1);

        // Disabled port drops everything
        port_enable[2] = 1'b0;
        for (int i = 0; i < N_OFF; i++) begin
            send_pkt(2, 1 + $unsigned($random(pkt_seed)) % MTU_BYTES);
        end
        send_pkt(0, 1 + $unsigned($random(pkt_seed)) % MTU_BYTES);
        send_pkt(3, 1 + $unsigned($random(pkt_seed)) % MTU_BYTES);
        drain(-1);
        port_enable[2] = 1'b1;

        for (int i = 0; i < NUM_PORTS; i++) begin
            check_cnts(i);
            assert (seen_drops[i] == total_drops[i]) else begin
                $display("** Error @ %0t: port %0d drop pulses %0d, expected %0d",
                         $time, i, seen_drops[i], total_drops[i]);
                other_errs++;
            end
        end

        // Clear port 0 only
        cnts_clear[0] = 1'b1;
        @(negedge egr_bus);
        cnts_clear[0] = 1'b0;
        exp_pkts[0]   = '0;
        exp_bytes[0]  = '0;
        exp_drops[0]  = '0;
        @(negedge egr_bus);
        for (int i = 0; i < NUM_PORTS; i++) begin
            check_cnts(i);
        end

        $display("Errors: beat %0d, counter %0d, other %0d", beat_errs, cnt_errs, other_errs);
        if (beat_errs + cnt_errs + other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
